// ==== arith_unit_if.sv ====
`timescale 1ns/1ns

interface arith_unit_if #(
  parameter int xlen = 32
);

  // request side, driven by the sequencer
  logic            go;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic            a_signed;
  logic            b_signed;

  // response side, driven by the unit
  // multiplier gives product halves, divider gives quotient in lo and remainder in hi
  logic [xlen-1:0] lo;
  logic [xlen-1:0] hi;
  logic            finished;

  modport ctrl (output go, op_a, op_b, a_signed, b_signed, input lo, hi, finished);

  modport unit (input go, op_a, op_b, a_signed, b_signed, output lo, hi, finished);

endinterface

// ==== muldiv_ctrl_pkg.sv ====
package muldiv_ctrl_pkg;

  // sequencer FSM
  // finish is the done cycle, a new start may be taken there too
  typedef enum logic [1:0] {
    idle   = 2'd0,
    run    = 2'd1,
    finish = 2'd2
  } seq_state_t;

  // which iterative unit owns the current operation
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } unit_sel_t;

endpackage

// ==== muldiv_exec.f ====
muldiv_isa_pkg.sv
muldiv_ctrl_pkg.sv
arith_unit_if.sv
muldiv_sequencer.sv
shift_add_multiplier.sv
restoring_divider.sv
muldiv_exec.sv
muldiv_exec_assertions.sv
muldiv_exec_tb.sv

// ==== muldiv_exec.sv ====
`timescale 1ns/1ns

module muldiv_exec #(
  parameter int xlen = muldiv_isa_pkg::word_width
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [2:0]            funct3,
  input  muldiv_isa_pkg::word_t op_a,
  input  muldiv_isa_pkg::word_t op_b,
  output logic                  busy,
  output logic                  done,
  output muldiv_isa_pkg::word_t result
);

  // one link per iterative unit
  arith_unit_if #(.xlen(xlen)) mul_if ();
  arith_unit_if #(.xlen(xlen)) div_if ();

  muldiv_sequencer #(.xlen(xlen)) sequencer_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .funct3   (muldiv_isa_pkg::muldiv_funct3_t'(funct3)),
    .op_a     (op_a),
    .op_b     (op_b),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .mul_port (mul_if),
    .div_port (div_if)
  );

  shift_add_multiplier #(.xlen(xlen)) multiplier_i (
    .clk  (clk),
    .rst  (rst),
    .port (mul_if)
  );

  restoring_divider #(.xlen(xlen)) divider_i (
    .clk  (clk),
    .rst  (rst),
    .port (div_if)
  );

endmodule

// ==== muldiv_exec_assertions.sv ====
`timescale 1ns/1ns

module muldiv_exec_assertions (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic done
);

  // accepted start still waiting for its done
  logic op_open;

  // number of failed assertions
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_open <= 1'b0;
    end else if (start && !busy) begin
      op_open <= 1'b1;
    end else if (done) begin
      op_open <= 1'b0;
    end
  end

  done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      fail_count++;
    end

  done_needs_start: assert property (@(posedge clk) disable iff (rst) done |-> op_open)
    else begin
      $error("done without an accepted start");
      fail_count++;
    end

  // outputs settle one cycle after reset is sampled
  idle_after_reset: assert property (@(posedge clk) rst |=> (!busy && !done))
    else begin
      $error("busy or done high right after reset");
      fail_count++;
    end

endmodule

// ==== muldiv_exec_tb.sv ====
`timescale 1ns/1ns

module muldiv_exec_tb;

  localparam int num_rows        = 22;
  localparam int xlen            = 32;
  localparam int clk_period      = 10;
  localparam int watchdog_cycles = num_rows * 50 + 100;
  localparam int quiet_cycles    = 40;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic [2:0]            funct3;
  muldiv_isa_pkg::word_t op_a;
  muldiv_isa_pkg::word_t op_b;
  logic                  busy;
  logic                  done;
  muldiv_isa_pkg::word_t result;

  // four words per row in the order funct3, op_a, op_b, expected
  muldiv_isa_pkg::word_t golden [0:4*num_rows-1];

  integer                seed;
  int                    done_count = 0;
  int                    error_count = 0;
  muldiv_isa_pkg::word_t last_result;

  muldiv_exec #(.xlen(xlen)) muldiv_exec_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .funct3 (funct3),
    .op_a   (op_a),
    .op_b   (op_b),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  bind muldiv_exec muldiv_exec_assertions assertions_i (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // count done pulses
  always @(negedge clk) begin
    if (!rst && done) begin
      done_count <= done_count + 1;
    end
  end

  task automatic check_value(input muldiv_isa_pkg::word_t actual,
                             input muldiv_isa_pkg::word_t expected,
                             input int idx, input string what);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns: op %0d %s got %h, expected %h",
               $time, idx, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // ************************************************************************
  // one operation plus a second start while busy
  // ************************************************************************
  task automatic run_op(input int idx);
    muldiv_isa_pkg::word_t expected;
    expected = golden[4*idx+3];
    start    = 1'b1;
    funct3   = golden[4*idx][2:0];
    op_a     = golden[4*idx+1];
    op_b     = golden[4*idx+2];
    @(negedge clk);
    check_value(muldiv_isa_pkg::word_t'(busy), 32'd1, idx, "busy after start");
    // second start must be dropped while the unit runs
    funct3 = funct3 ^ 3'b100;
    op_a   = ~op_a;
    op_b   = ~op_b;
    @(negedge clk);
    start = 1'b0;
    while (!done) begin
      check_value(result, last_result, idx, "result held while busy");
      @(negedge clk);
    end
    check_value(result, expected, idx, "result");
    last_result = expected;
  endtask

  // idle cycles with start low and noise on the other inputs
  task automatic idle_gap(input int idx, input int cycles);
    repeat (cycles) begin
      funct3 = 3'($random(seed));
      op_a   = $random(seed);
      op_b   = $random(seed);
      @(negedge clk);
      check_value(result, last_result, idx, "result held while idle");
    end
  endtask

  initial begin
    seed        = 32'h9e72_85ab;
    rst         = 1'b1;
    start       = 1'b0;
    funct3      = 3'b000;
    op_a        = '0;
    op_b        = '0;
    last_result = '0;
    $readmemh("muldiv_golden.txt", golden);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value(result, 32'd0, -1, "result after reset");

    for (int i = 0; i < num_rows; i++) begin
      run_op(i);
      idle_gap(i, $unsigned($random(seed)) % 4);
    end

    // nothing queued behind the ignored starts
    idle_gap(num_rows, quiet_cycles);
    check_value(muldiv_isa_pkg::word_t'(done_count), muldiv_isa_pkg::word_t'(num_rows),
                num_rows, "done count");

    error_count += muldiv_exec_i.assertions_i.fail_count;
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("%0d assertion failures during the run", error_count);
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== muldiv_golden.txt ====
// columns: funct3, operand a, operand b, expected result (all hex)
// funct3: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 div, 5 divu, 6 rem, 7 remu
0 00000007 00000006 0000002a
0 00000064 fffffff6 fffffc18
1 fffffffd 00000005 ffffffff
1 80000000 80000000 40000000
2 ffffffff ffffffff ffffffff
2 12345678 80000000 091a2b3c
3 ffffffff ffffffff fffffffe
3 12345678 00010000 00001234
4 00000014 fffffffa fffffffd
6 00000014 fffffffa 00000002
4 ffffffec 00000006 fffffffd
6 ffffffec 00000006 fffffffe
5 ffffffec 00000006 2aaaaaa7
7 ffffffec 00000006 00000002
4 ffffff9c fffffff9 0000000e
6 ffffff9c fffffff9 fffffffe
4 0000002a 00000000 ffffffff
5 80000000 00000000 ffffffff
6 fffffff3 00000000 fffffff3
7 12345678 00000000 12345678
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000

// ==== muldiv_isa_pkg.sv ====
package muldiv_isa_pkg;

  // data path width of the RV32M execute path
  localparam int word_width = 32;

  // one register-sized operand or result
  typedef logic [word_width-1:0] word_t;

  // full product, or remainder and quotient side by side
  typedef logic [2*word_width-1:0] dword_t;

  // ***************************************************************************
  // M-extension funct3 codes (OP opcode, funct7 = 7'b0000001)
  // ***************************************************************************
  typedef enum logic [2:0] {
    mul    = 3'b000,
    mulh   = 3'b001,
    mulhsu = 3'b010,
    mulhu  = 3'b011,
    div    = 3'b100,
    divu   = 3'b101,
    rem    = 3'b110,
    remu   = 3'b111
  } muldiv_funct3_t;

endpackage

// ==== muldiv_sequencer.sv ====
`timescale 1ns/1ns

module muldiv_sequencer #(
  parameter int xlen = 32
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  muldiv_isa_pkg::muldiv_funct3_t funct3,
  input  muldiv_isa_pkg::word_t          op_a,
  input  muldiv_isa_pkg::word_t          op_b,
  output logic                           busy,
  output logic                           done,
  output muldiv_isa_pkg::word_t          result,
  arith_unit_if.ctrl                     mul_port,
  arith_unit_if.ctrl                     div_port
);

  muldiv_ctrl_pkg::seq_state_t state;
  muldiv_ctrl_pkg::unit_sel_t  unit_d;
  muldiv_ctrl_pkg::unit_sel_t  unit_q;
  logic                        a_signed_d;
  logic                        b_signed_d;
  logic                        take_hi_d;
  logic                        a_signed_q;
  logic                        b_signed_q;
  logic                        take_hi_q;
  logic [xlen-1:0]             op_a_q;
  logic [xlen-1:0]             op_b_q;
  logic                        mul_go;
  logic                        div_go;
  logic                        accept;
  logic                        unit_finished;
  logic [xlen-1:0]             unit_result;

  // ***************************************************************************
  // funct3 decode
  // ***************************************************************************
  always_comb begin
    unit_d     = muldiv_ctrl_pkg::unit_mul;
    a_signed_d = 1'b1;
    b_signed_d = 1'b1;
    take_hi_d  = 1'b0;
    unique case (funct3)
      muldiv_isa_pkg::mul: begin
        take_hi_d = 1'b0;
      end
      muldiv_isa_pkg::mulh: begin
        take_hi_d = 1'b1;
      end
      muldiv_isa_pkg::mulhsu: begin
        b_signed_d = 1'b0;
        take_hi_d  = 1'b1;
      end
      muldiv_isa_pkg::mulhu: begin
        a_signed_d = 1'b0;
        b_signed_d = 1'b0;
        take_hi_d  = 1'b1;
      end
      muldiv_isa_pkg::div: begin
        unit_d = muldiv_ctrl_pkg::unit_div;
      end
      muldiv_isa_pkg::divu: begin
        unit_d     = muldiv_ctrl_pkg::unit_div;
        a_signed_d = 1'b0;
        b_signed_d = 1'b0;
      end
      muldiv_isa_pkg::rem: begin
        unit_d    = muldiv_ctrl_pkg::unit_div;
        take_hi_d = 1'b1;
      end
      muldiv_isa_pkg::remu: begin
        unit_d     = muldiv_ctrl_pkg::unit_div;
        a_signed_d = 1'b0;
        b_signed_d = 1'b0;
        take_hi_d  = 1'b1;
      end
    endcase
  end

  // a start in the done cycle is taken as well, busy is already low there
  assign accept = start && (state != muldiv_ctrl_pkg::run);

  assign unit_finished = (unit_q == muldiv_ctrl_pkg::unit_div) ?
                         div_port.finished : mul_port.finished;

  // result select: low/high product word, quotient or remainder
  always_comb begin
    if (unit_q == muldiv_ctrl_pkg::unit_div) begin
      unit_result = take_hi_q ? div_port.hi : div_port.lo;
    end else begin
      unit_result = take_hi_q ? mul_port.hi : mul_port.lo;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= muldiv_ctrl_pkg::idle;
      unit_q     <= muldiv_ctrl_pkg::unit_mul;
      a_signed_q <= 1'b0;
      b_signed_q <= 1'b0;
      take_hi_q  <= 1'b0;
      mul_go     <= 1'b0;
      div_go     <= 1'b0;
      result     <= '0;
    end else begin
      mul_go <= 1'b0;
      div_go <= 1'b0;
      if (state == muldiv_ctrl_pkg::run) begin
        if (unit_finished) begin
          result <= unit_result;
          state  <= muldiv_ctrl_pkg::finish;
        end
      end else if (accept) begin
        state      <= muldiv_ctrl_pkg::run;
        unit_q     <= unit_d;
        a_signed_q <= a_signed_d;
        b_signed_q <= b_signed_d;
        take_hi_q  <= take_hi_d;
        mul_go     <= (unit_d == muldiv_ctrl_pkg::unit_mul);
        div_go     <= (unit_d == muldiv_ctrl_pkg::unit_div);
      end else begin
        state <= muldiv_ctrl_pkg::idle;
      end
    end
  end

  // operands stay put until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  assign busy = (state == muldiv_ctrl_pkg::run);
  assign done = (state == muldiv_ctrl_pkg::finish);

  assign mul_port.go       = mul_go;
  assign mul_port.op_a     = op_a_q;
  assign mul_port.op_b     = op_b_q;
  assign mul_port.a_signed = a_signed_q;
  assign mul_port.b_signed = b_signed_q;

  assign div_port.go       = div_go;
  assign div_port.op_a     = op_a_q;
  assign div_port.op_b     = op_b_q;
  assign div_port.a_signed = a_signed_q;
  assign div_port.b_signed = b_signed_q;

endmodule

// ==== restoring_divider.sv ====
`timescale 1ns/1ns

module restoring_divider #(
  parameter int xlen = 32
) (
  input logic         clk,
  input logic         rst,
  arith_unit_if.unit  port
);

  localparam int              cnt_w   = $clog2(xlen);
  localparam logic [xlen-1:0] min_val = {1'b1, {(xlen-1){1'b0}}};

  logic                   running;
  logic [cnt_w-1:0]       count;
  logic                   a_neg;
  logic                   b_neg;
  logic [xlen-1:0]        mag_a;
  logic [xlen-1:0]        mag_b;
  logic [xlen-1:0]        divisor;
  logic [xlen-1:0]        dividend;
  logic                   neg_quo;
  logic                   neg_rem;
  logic                   div_zero;
  logic                   overflow;
  logic [xlen:0]          rem_shift;
  logic [xlen:0]          diff;
  logic [xlen-1:0]        quo;
  logic [xlen-1:0]        rem_mag;
  muldiv_isa_pkg::dword_t pair;
  muldiv_isa_pkg::dword_t pair_next;

  assign a_neg = port.a_signed && port.op_a[xlen-1];
  assign b_neg = port.b_signed && port.op_b[xlen-1];
  assign mag_a = a_neg ? -port.op_a : port.op_a;
  assign mag_b = b_neg ? -port.op_b : port.op_b;

  // ***************************************************************************
  // one restoring step
  // pair holds partial remainder on top, dividend/quotient bits below
  // ***************************************************************************
  always_comb begin
    rem_shift = pair[2*xlen-1:xlen-1];
    diff      = rem_shift - {1'b0, divisor};
    if (rem_shift >= {1'b0, divisor}) begin
      pair_next = {diff[xlen-1:0], pair[xlen-2:0], 1'b1};
    end else begin
      pair_next = {rem_shift[xlen-1:0], pair[xlen-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      running       <= 1'b0;
      count         <= '0;
      port.finished <= 1'b0;
    end else begin
      port.finished <= 1'b0;
      if (!running && port.go) begin
        running <= 1'b1;
        count   <= '0;
      end else if (running) begin
        count <= count + 1'b1;
        if (count == cnt_w'(xlen - 1)) begin
          running       <= 1'b0;
          port.finished <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!running && port.go) begin
      pair     <= muldiv_isa_pkg::dword_t'(mag_a);
      divisor  <= mag_b;
      dividend <= port.op_a;
      neg_quo  <= a_neg ^ b_neg;
      neg_rem  <= a_neg;
      div_zero <= (port.op_b == '0);
      overflow <= port.a_signed && port.b_signed &&
                  (port.op_a == min_val) && (port.op_b == '1);
    end else if (running) begin
      pair <= pair_next;
    end
  end

  assign quo     = pair[xlen-1:0];
  assign rem_mag = pair[2*xlen-1:xlen];

  // ISA corner cases first, then sign correction
  always_comb begin
    if (div_zero) begin
      port.lo = '1;
      port.hi = dividend;
    end else if (overflow) begin
      port.lo = min_val;
      port.hi = '0;
    end else begin
      port.lo = neg_quo ? -quo : quo;
      // remainder follows the dividend
      port.hi = neg_rem ? -rem_mag : rem_mag;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module muldiv_exec_tb -f muldiv_exec.f
./obj_dir/Vmuldiv_exec_tb 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// ==== shift_add_multiplier.sv ====
`timescale 1ns/1ns

module shift_add_multiplier #(
  parameter int xlen = 32
) (
  input logic         clk,
  input logic         rst,
  arith_unit_if.unit  port
);

  localparam int cnt_w = $clog2(xlen);

  logic                   running;
  logic [cnt_w-1:0]       count;
  logic                   negate;
  logic                   a_neg;
  logic                   b_neg;
  logic [xlen-1:0]        mag_a;
  logic [xlen-1:0]        mag_b;
  logic [xlen-1:0]        mplier;
  muldiv_isa_pkg::dword_t mcand;
  muldiv_isa_pkg::dword_t acc;
  muldiv_isa_pkg::dword_t product;

  // magnitudes, only for operands flagged signed
  assign a_neg = port.a_signed && port.op_a[xlen-1];
  assign b_neg = port.b_signed && port.op_b[xlen-1];
  assign mag_a = a_neg ? -port.op_a : port.op_a;
  assign mag_b = b_neg ? -port.op_b : port.op_b;

  // ***************************************************************************
  // step counter, one shift-and-add per cycle
  // ***************************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      running       <= 1'b0;
      count         <= '0;
      port.finished <= 1'b0;
    end else begin
      port.finished <= 1'b0;
      if (!running && port.go) begin
        running <= 1'b1;
        count   <= '0;
      end else if (running) begin
        count <= count + 1'b1;
        if (count == cnt_w'(xlen - 1)) begin
          running       <= 1'b0;
          port.finished <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!running && port.go) begin
      mcand  <= muldiv_isa_pkg::dword_t'(mag_a);
      mplier <= mag_b;
      acc    <= '0;
      negate <= a_neg ^ b_neg;
    end else if (running) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign correction on the full-width product
  assign product = negate ? -acc : acc;

  assign port.lo = product[xlen-1:0];
  assign port.hi = product[2*xlen-1:xlen];

endmodule
